// File: cache_bank.f
verilog/cache_bank_pkg.sv
verilog/bank_ifs.sv
verilog/line_store.sv
verilog/rrip_select.sv
verilog/bank_ctrl.sv
verilog/cache_bank.sv
sim/tb_cache_bank.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the cache bank testbench with Verilator, run it and check the log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=tb_cache_bank

verilator --binary --timing --assert --top-module tb_cache_bank \
    -f cache_bank.f -o "$BIN"
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Errors found" "$LOG"; then
    echo "simulation FAILED, see $LOG"
    exit 1
fi

echo "simulation passed"
exit 0

// File: sim/tb_cache_bank.sv
`timescale 1ns/1ps

module tb_cache_bank
    import cache_bank_pkg::*;
;

    localparam int WAYS         = 4;
    localparam int RRPV_BITS    = 2;
    localparam int RRPV_MAX     = (1 << RRPV_BITS) - 1;
    localparam int SETS         = 1 << SET_BITS;
    localparam int CLK_PERIOD   = 40;
    // upper bound on requests issued, and cycles per request at most delay
    localparam int N_REQUESTS   = 100;
    localparam int WORST_CYCLES = 16;
    localparam int WATCHDOG_NS  = (N_REQUESTS * WORST_CYCLES + 20) * CLK_PERIOD;

    logic                  i_clk;
    logic                  i_nreset;
    logic [1:0]            i_request_type;
    logic [ADDR_WIDTH-1:0] i_addr;
    logic                  i_type_valid;
    logic                  o_type_ready;
    logic [DATA_WIDTH-1:0] i_data;
    logic [DATA_WIDTH-1:0] o_pe_data_o;
    logic                  o_pe_data_o_valid;
    logic                  i_pe_data_o_ready;
    logic [ADDR_WIDTH-1:0] o_dram_addr;
    logic [DATA_WIDTH-1:0] i_dram_data;
    logic                  i_dram_data_i_valid;
    logic                  o_dram_data_i_ready;
    logic [DATA_WIDTH-1:0] o_dram_data_o;
    logic                  o_dram_data_o_valid;
    logic                  i_dram_data_o_ready;

    // reference model of the bank
    logic [TAG_BITS-1:0]   m_tag   [SETS][WAYS];
    logic [DATA_WIDTH-1:0] m_data  [SETS][WAYS];
    logic                  m_valid [SETS][WAYS];
    logic                  m_dirty [SETS][WAYS];
    int                    m_rrpv  [SETS][WAYS];

    int    seed = 85431;
    int    check_count = 0;
    int    error_count = 0;
    string test_name = "reset";

    cache_bank #(
        .WAYS      (WAYS),
        .RRPV_BITS (RRPV_BITS)
    ) cache_bank_inst (
        .i_clk               (i_clk),
        .i_nreset            (i_nreset),
        .i_request_type      (i_request_type),
        .i_addr              (i_addr),
        .i_type_valid        (i_type_valid),
        .o_type_ready        (o_type_ready),
        .i_data              (i_data),
        .o_pe_data_o         (o_pe_data_o),
        .o_pe_data_o_valid   (o_pe_data_o_valid),
        .i_pe_data_o_ready   (i_pe_data_o_ready),
        .o_dram_addr         (o_dram_addr),
        .i_dram_data         (i_dram_data),
        .i_dram_data_i_valid (i_dram_data_i_valid),
        .o_dram_data_i_ready (o_dram_data_i_ready),
        .o_dram_data_o       (o_dram_data_o),
        .o_dram_data_o_valid (o_dram_data_o_valid),
        .i_dram_data_o_ready (i_dram_data_o_ready)
    );

    initial begin
        i_clk = 1'b0;
        forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired during '%s', a handshake never completed", test_name);
        $display("Errors found");
        $finish;
    end

    // ------------------------------------------------------------------------
    // checks and helpers
    // ------------------------------------------------------------------------
    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        check_count++;
        assert (expected === actual) else begin
            $display("Mismatch %s: expected %h, got %h", name, expected, actual);
            error_count++;
        end
    endtask

    task automatic require(input logic cond, input string what);
        check_count++;
        assert (cond) else begin
            $display("%s", what);
            error_count++;
        end
    endtask

    function automatic int pick_delay();
        return int'($unsigned($random(seed)) % 4);
    endfunction

    // DRAM contents as seen by fills
    function automatic logic [DATA_WIDTH-1:0] fill_pattern(input logic [ADDR_WIDTH-1:0] addr);
        return {addr[7:0], addr[15:8]} ^ addr[31:16] ^ 16'h3c5a;
    endfunction

    function automatic logic [ADDR_WIDTH-1:0] make_addr(input logic [TAG_BITS-1:0] tag,
                                                        input logic [SET_BITS-1:0] s,
                                                        input logic [OFFSET_BITS-1:0] off);
        return {tag, s, off};
    endfunction

    function automatic int find_way(input logic [ADDR_WIDTH-1:0] addr);
        int s;
        s = int'(addr[OFFSET_BITS +: SET_BITS]);
        for (int w = 0; w < WAYS; w++) begin
            if (m_valid[s][w] && m_tag[s][w] == addr[ADDR_WIDTH-1 -: TAG_BITS])
                return w;
        end
        return -1;
    endfunction

    // first empty way, else lowest way with the oldest prediction
    function automatic int choose_victim(input int s);
        int best;
        for (int w = 0; w < WAYS; w++) begin
            if (!m_valid[s][w])
                return w;
        end
        best = 0;
        for (int w = 1; w < WAYS; w++) begin
            if (m_rrpv[s][w] > m_rrpv[s][best])
                best = w;
        end
        return best;
    endfunction

    task automatic report_test(input int errors_before);
        $display("test %-32s %s", test_name,
                 (error_count == errors_before) ? "passed" : "FAILED");
    endtask

    // ------------------------------------------------------------------------
    // one request with PE and DRAM responders, then the model update
    // ------------------------------------------------------------------------
    task automatic run_request(input logic [1:0] kind, input logic [ADDR_WIDTH-1:0] addr,
                               input logic [DATA_WIDTH-1:0] wdata);
        int                    s;
        int                    way;
        int                    victim;
        int                    cycles;
        int                    pe_wait;
        int                    wb_wait;
        int                    fill_wait;
        logic                  miss;
        logic                  exp_wb;
        logic                  pe_done;
        logic                  wb_done;
        logic                  fill_done;
        logic [DATA_WIDTH-1:0] exp_read;
        logic [ADDR_WIDTH-1:0] exp_wb_addr;
        logic [DATA_WIDTH-1:0] exp_wb_data;
        logic [DATA_WIDTH-1:0] fill_word;
        s           = int'(addr[OFFSET_BITS +: SET_BITS]);
        way         = find_way(addr);
        victim      = choose_victim(s);
        miss        = kind == REQ_FETCH && way < 0;
        exp_read    = (way >= 0) ? m_data[s][way] : '0;
        exp_wb      = miss && m_valid[s][victim] && m_dirty[s][victim];
        exp_wb_addr = {m_tag[s][victim], addr[OFFSET_BITS +: SET_BITS], {OFFSET_BITS{1'b0}}};
        exp_wb_data = m_data[s][victim];
        fill_word   = fill_pattern(addr);
        pe_wait     = -1;
        wb_wait     = -1;
        fill_wait   = -1;
        pe_done     = 1'b0;
        wb_done     = 1'b0;
        fill_done   = 1'b0;
        cycles      = 0;

        while (!o_type_ready)
            @(negedge i_clk);
        i_type_valid   = 1'b1;
        i_request_type = kind;
        i_addr         = addr;
        i_data         = wdata;
        @(negedge i_clk);
        i_type_valid = 1'b0;
        require(!o_type_ready, "o_type_ready stayed high after a request was accepted");

        while (!o_type_ready) begin
            i_pe_data_o_ready   = 1'b0;
            i_dram_data_o_ready = 1'b0;
            i_dram_data_i_valid = 1'b0;
            if (o_pe_data_o_valid) begin
                require(kind == REQ_READ && !pe_done, "PE return raised where none was due");
                compare_value("o_pe_data_o", 32'(exp_read), 32'(o_pe_data_o));
                if (pe_wait < 0)
                    pe_wait = pick_delay();
                if (pe_wait == 0) begin
                    i_pe_data_o_ready = 1'b1;
                    pe_done = 1'b1;
                end else begin
                    pe_wait--;
                end
            end else begin
                require(!(pe_wait >= 0 && !pe_done),
                        "o_pe_data_o_valid dropped before its handshake");
            end
            if (o_dram_data_o_valid) begin
                require(exp_wb && !wb_done, "write-back raised where no dirty victim was due");
                compare_value("o_dram_addr", exp_wb_addr, o_dram_addr);
                compare_value("o_dram_data_o", 32'(exp_wb_data), 32'(o_dram_data_o));
                if (wb_wait < 0)
                    wb_wait = pick_delay();
                if (wb_wait == 0) begin
                    i_dram_data_o_ready = 1'b1;
                    wb_done = 1'b1;
                end else begin
                    wb_wait--;
                end
            end else begin
                require(!(wb_wait >= 0 && !wb_done),
                        "o_dram_data_o_valid dropped before its handshake");
            end
            if (o_dram_data_i_ready) begin
                require(miss && !fill_done, "fill requested where no miss was due");
                require(wb_done || !exp_wb, "fill requested before the write-back finished");
                compare_value("o_dram_addr", addr, o_dram_addr);
                if (fill_wait < 0)
                    fill_wait = pick_delay();
                if (fill_wait == 0) begin
                    i_dram_data_i_valid = 1'b1;
                    i_dram_data = fill_word;
                    fill_done = 1'b1;
                end else begin
                    fill_wait--;
                end
            end else begin
                require(!(fill_wait >= 0 && !fill_done),
                        "o_dram_data_i_ready dropped before the fill arrived");
            end
            cycles++;
            @(negedge i_clk);
        end

        i_pe_data_o_ready   = 1'b0;
        i_dram_data_o_ready = 1'b0;
        i_dram_data_i_valid = 1'b0;
        require(kind != REQ_READ || pe_done, "read ended without a PE return");
        require(!exp_wb || wb_done, "fetch miss ended without the expected write-back");
        require(!miss || fill_done, "fetch miss ended without a fill");
        require(kind == REQ_READ || miss || cycles == 1,
                "write or fetch hit took more than one lookup cycle");
        compare_value("o_pe_data_o_valid", 32'(0), 32'(o_pe_data_o_valid));
        compare_value("o_dram_data_o_valid", 32'(0), 32'(o_dram_data_o_valid));
        compare_value("o_dram_data_i_ready", 32'(0), 32'(o_dram_data_i_ready));

        if (kind == REQ_WRITE && way >= 0) begin
            m_data[s][way]  = wdata;
            m_dirty[s][way] = 1'b1;
        end else if (kind == REQ_FETCH && way >= 0) begin
            m_rrpv[s][way] = 0;
        end else if (miss) begin
            // age the rest of the set, insert at long re-reference
            for (int w = 0; w < WAYS; w++) begin
                if (w == victim)
                    m_rrpv[s][w] = RRPV_MAX - 1;
                else if (m_rrpv[s][w] < RRPV_MAX)
                    m_rrpv[s][w]++;
            end
            m_tag[s][victim]   = addr[ADDR_WIDTH-1 -: TAG_BITS];
            m_valid[s][victim] = 1'b1;
            m_dirty[s][victim] = 1'b0;
            m_data[s][victim]  = fill_word;
        end
    endtask

    // ------------------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------------------
    initial begin
        int               errors_before;
        logic [1:0]       kind;
        logic [TAG_BITS-1:0] tag;
        logic [SET_BITS-1:0] s;
        i_nreset            = 1'b0;
        i_request_type      = REQ_FETCH;
        i_addr              = '0;
        i_type_valid        = 1'b0;
        i_data              = '0;
        i_pe_data_o_ready   = 1'b0;
        i_dram_data         = '0;
        i_dram_data_i_valid = 1'b0;
        i_dram_data_o_ready = 1'b0;
        for (int si = 0; si < SETS; si++) begin
            for (int w = 0; w < WAYS; w++) begin
                m_tag[si][w]   = '0;
                m_data[si][w]  = '0;
                m_valid[si][w] = 1'b0;
                m_dirty[si][w] = 1'b0;
                m_rrpv[si][w]  = RRPV_MAX;
            end
        end
        repeat (3) @(posedge i_clk);
        @(negedge i_clk);
        i_nreset = 1'b1;
        @(negedge i_clk);

        test_name = "1 reset state and empty reads";
        errors_before = error_count;
        compare_value("o_type_ready", 32'(1), 32'(o_type_ready));
        compare_value("o_pe_data_o_valid", 32'(0), 32'(o_pe_data_o_valid));
        compare_value("o_dram_data_o_valid", 32'(0), 32'(o_dram_data_o_valid));
        compare_value("o_dram_data_i_ready", 32'(0), 32'(o_dram_data_i_ready));
        run_request(REQ_READ, make_addr(24'h000000, 4'd0, 4'h0), '0);
        run_request(REQ_READ, make_addr(24'h12ab34, 4'd7, 4'h8), '0);
        run_request(REQ_READ, make_addr(24'hffffff, 4'd15, 4'hf), '0);
        report_test(errors_before);

        test_name = "2 fetch miss, read, fetch hit";
        errors_before = error_count;
        run_request(REQ_FETCH, make_addr(24'h0000a1, 4'd2, 4'h0), '0);
        run_request(REQ_READ, make_addr(24'h0000a1, 4'd2, 4'h4), '0);
        run_request(REQ_FETCH, make_addr(24'h0000a1, 4'd2, 4'h0), '0);
        report_test(errors_before);

        test_name = "3 write hit and write miss";
        errors_before = error_count;
        run_request(REQ_FETCH, make_addr(24'h0000b2, 4'd3, 4'h0), '0);
        run_request(REQ_WRITE, make_addr(24'h0000b2, 4'd3, 4'h0), 16'hbeef);
        run_request(REQ_READ, make_addr(24'h0000b2, 4'd3, 4'h0), '0);
        run_request(REQ_WRITE, make_addr(24'h0000c3, 4'd3, 4'h0), 16'h1234);
        run_request(REQ_READ, make_addr(24'h0000c3, 4'd3, 4'h0), '0);
        report_test(errors_before);

        test_name = "4 victim choice and write-back";
        errors_before = error_count;
        for (int t = 0; t < 4; t++)
            run_request(REQ_FETCH, make_addr(TAG_BITS'(16 + t), 4'd5, 4'h0), '0);
        run_request(REQ_WRITE, make_addr(24'h000011, 4'd5, 4'h0), 16'h1111);
        run_request(REQ_WRITE, make_addr(24'h000013, 4'd5, 4'h0), 16'h3333);
        // first eviction is clean, the second one dirty
        run_request(REQ_FETCH, make_addr(24'h000014, 4'd5, 4'h0), '0);
        run_request(REQ_FETCH, make_addr(24'h000015, 4'd5, 4'h0), '0);
        run_request(REQ_READ, make_addr(24'h000014, 4'd5, 4'h0), '0);
        run_request(REQ_READ, make_addr(24'h000015, 4'd5, 4'h0), '0);
        report_test(errors_before);

        test_name = "5 back-pressure on dirty evictions";
        errors_before = error_count;
        for (int t = 0; t < 4; t++)
            run_request(REQ_FETCH, make_addr(TAG_BITS'(32 + t), 4'd9, 4'h0), '0);
        for (int t = 0; t < 4; t++)
            run_request(REQ_WRITE, make_addr(TAG_BITS'(32 + t), 4'd9, 4'h0), 16'(16'ha000 + t));
        for (int t = 0; t < 4; t++)
            run_request(REQ_READ, make_addr(TAG_BITS'(32 + t), 4'd9, 4'h0), '0);
        for (int t = 0; t < 4; t++)
            run_request(REQ_FETCH, make_addr(TAG_BITS'(36 + t), 4'd9, 4'h0), '0);
        report_test(errors_before);

        test_name = "6 random request mix";
        errors_before = error_count;
        for (int n = 0; n < 60; n++) begin
            kind = 2'($unsigned($random(seed)) % 3);
            tag  = TAG_BITS'($unsigned($random(seed)) % 6);
            s    = SET_BITS'(12 + $unsigned($random(seed)) % 4);
            run_request(kind, make_addr(tag, s, OFFSET_BITS'($random(seed))),
                        16'($random(seed)));
        end
        report_test(errors_before);

        $display("%0d checks, %0d errors", check_count, error_count);
        if (error_count == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

// File: verilog/bank_ctrl.sv
`timescale 1ns/1ps

module bank_ctrl
    import cache_bank_pkg::*;
#(
    parameter int WAYS      = 4,
    parameter int RRPV_BITS = 2
) (
    input  logic                  i_clk,
    input  logic                  i_nreset,
    // PE request
    input  logic [1:0]            i_request_type,
    input  logic [ADDR_WIDTH-1:0] i_addr,
    input  logic                  i_type_valid,
    output logic                  o_type_ready,
    input  logic [DATA_WIDTH-1:0] i_data,
    // PE return
    output logic [DATA_WIDTH-1:0] o_pe_data_o,
    output logic                  o_pe_data_o_valid,
    input  logic                  i_pe_data_o_ready,
    // DRAM
    output logic [ADDR_WIDTH-1:0] o_dram_addr,
    input  logic [DATA_WIDTH-1:0] i_dram_data,
    input  logic                  i_dram_data_i_valid,
    output logic                  o_dram_data_i_ready,
    output logic [DATA_WIDTH-1:0] o_dram_data_o,
    output logic                  o_dram_data_o_valid,
    input  logic                  i_dram_data_o_ready,
    line_if.ctrl                  line_bus,
    rrip_if.ctrl                  rrip_bus
);

    localparam logic [2:0] ST_IDLE       = 3'd0;
    localparam logic [2:0] ST_LOOKUP     = 3'd1;
    localparam logic [2:0] ST_SEND_PE    = 3'd2;
    localparam logic [2:0] ST_WRITE_BACK = 3'd3;
    localparam logic [2:0] ST_FILL       = 3'd4;

    logic [2:0]            state;
    logic [2:0]            state_nxt;
    logic [1:0]            type_q;
    line_addr_u            req_q;
    logic [DATA_WIDTH-1:0] data_q;
    logic [DATA_WIDTH-1:0] pe_data_q;
    logic [WAYS-1:0]       victim_q;
    line_addr_u            wb_addr;
    logic [DATA_WIDTH-1:0] wb_data;
    logic                  accept;
    logic                  lookup;
    logic                  fetch_miss;

    assign accept     = i_type_valid && o_type_ready;
    assign lookup     = (state == ST_LOOKUP);
    assign fetch_miss = lookup && type_q == REQ_FETCH && !line_bus.hit;

    // -------------------------------------------------------------------------
    // request FSM
    // -------------------------------------------------------------------------
    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: begin
                if (accept)
                    state_nxt = ST_LOOKUP;
            end
            ST_LOOKUP: begin
                if (type_q == REQ_READ)
                    state_nxt = ST_SEND_PE;
                else if (fetch_miss)
                    state_nxt = line_bus.victim_dirty ? ST_WRITE_BACK : ST_FILL;
                else
                    state_nxt = ST_IDLE;
            end
            ST_SEND_PE: begin
                if (i_pe_data_o_ready)
                    state_nxt = ST_IDLE;
            end
            ST_WRITE_BACK: begin
                if (i_dram_data_o_ready)
                    state_nxt = ST_FILL;
            end
            ST_FILL: begin
                if (i_dram_data_i_valid)
                    state_nxt = ST_IDLE;
            end
            default: state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (!i_nreset)
            state <= ST_IDLE;
        else
            state <= state_nxt;
    end

    // request, read result and victim capture
    always_ff @(posedge i_clk) begin
        if (accept) begin
            type_q    <= i_request_type;
            req_q.raw <= i_addr;
            data_q    <= i_data;
        end
        if (lookup)
            pe_data_q <= line_bus.hit_data;
        if (fetch_miss) begin
            victim_q                <= rrip_bus.victim_way;
            wb_addr.fields.tag      <= line_bus.victim_tag;
            wb_addr.fields.set      <= req_q.fields.set;
            wb_addr.fields.offset   <= '0;
            wb_data                 <= line_bus.victim_data;
        end
    end

    // -------------------------------------------------------------------------
    // store strobes
    // -------------------------------------------------------------------------
    assign line_bus.req_addr  = req_q;
    assign line_bus.fill_en   = (state == ST_FILL) && i_dram_data_i_valid;
    assign line_bus.fill_data = i_dram_data;
    // live victim while deciding, latched one afterwards
    assign line_bus.fill_way  = lookup ? rrip_bus.victim_way : victim_q;
    assign line_bus.wr_hit_en = lookup && type_q == REQ_WRITE && line_bus.hit;
    assign line_bus.wr_data   = data_q;

    assign rrip_bus.set_idx   = req_q.fields.set;
    assign rrip_bus.valid_vec = line_bus.valid_vec;
    assign rrip_bus.hit_way   = line_bus.hit_way;
    assign rrip_bus.touch_en  = lookup && type_q == REQ_FETCH && line_bus.hit;
    assign rrip_bus.miss_en   = fetch_miss;

    // outputs
    assign o_type_ready        = (state == ST_IDLE);
    assign o_pe_data_o         = pe_data_q;
    assign o_pe_data_o_valid   = (state == ST_SEND_PE);
    assign o_dram_data_o       = wb_data;
    assign o_dram_data_o_valid = (state == ST_WRITE_BACK);
    assign o_dram_data_i_ready = (state == ST_FILL);
    assign o_dram_addr         = (state == ST_FILL) ? req_q.raw : wb_addr.raw;

endmodule

// File: verilog/bank_ifs.sv
`timescale 1ns/1ps

// lookup, fill and write-hit path between controller and line store
interface line_if
    import cache_bank_pkg::*;
#(
    parameter int WAYS = 4
) ();

    line_addr_u            req_addr;
    logic                  fill_en;
    logic [DATA_WIDTH-1:0] fill_data;
    logic [WAYS-1:0]       fill_way;
    logic                  wr_hit_en;
    logic [DATA_WIDTH-1:0] wr_data;

    logic                  hit;
    logic [WAYS-1:0]       hit_way;
    logic [WAYS-1:0]       valid_vec;
    logic [DATA_WIDTH-1:0] hit_data;
    logic [TAG_BITS-1:0]   victim_tag;
    logic [DATA_WIDTH-1:0] victim_data;
    logic                  victim_dirty;

    modport ctrl (
        output req_addr, fill_en, fill_data, fill_way, wr_hit_en, wr_data,
        input  hit, hit_way, valid_vec, hit_data, victim_tag, victim_data, victim_dirty
    );

    modport store (
        input  req_addr, fill_en, fill_data, fill_way, wr_hit_en, wr_data,
        output hit, hit_way, valid_vec, hit_data, victim_tag, victim_data, victim_dirty
    );

endinterface

// replacement state update and victim choice
interface rrip_if
    import cache_bank_pkg::*;
#(
    parameter int WAYS = 4
) ();

    logic [SET_BITS-1:0] set_idx;
    logic [WAYS-1:0]     valid_vec;
    logic [WAYS-1:0]     hit_way;
    logic                touch_en;
    logic                miss_en;
    logic [WAYS-1:0]     victim_way;

    modport ctrl (
        output set_idx, valid_vec, hit_way, touch_en, miss_en,
        input  victim_way
    );

    modport sel (
        input  set_idx, valid_vec, hit_way, touch_en, miss_en,
        output victim_way
    );

endinterface

// File: verilog/cache_bank.sv
`timescale 1ns/1ps

module cache_bank
    import cache_bank_pkg::*;
#(
    parameter int WAYS      = 4,
    parameter int RRPV_BITS = 2
) (
    input  logic                  i_clk,
    input  logic                  i_nreset,
    input  logic [1:0]            i_request_type,
    input  logic [ADDR_WIDTH-1:0] i_addr,
    input  logic                  i_type_valid,
    output logic                  o_type_ready,
    input  logic [DATA_WIDTH-1:0] i_data,
    output logic [DATA_WIDTH-1:0] o_pe_data_o,
    output logic                  o_pe_data_o_valid,
    input  logic                  i_pe_data_o_ready,
    output logic [ADDR_WIDTH-1:0] o_dram_addr,
    input  logic [DATA_WIDTH-1:0] i_dram_data,
    input  logic                  i_dram_data_i_valid,
    output logic                  o_dram_data_i_ready,
    output logic [DATA_WIDTH-1:0] o_dram_data_o,
    output logic                  o_dram_data_o_valid,
    input  logic                  i_dram_data_o_ready
);

    line_if #(.WAYS(WAYS)) line_bus ();
    rrip_if #(.WAYS(WAYS)) rrip_bus ();

    // tag, data, valid and dirty arrays
    line_store #(
        .WAYS(WAYS)
    ) line_store_inst (
        .i_clk     (i_clk),
        .i_nreset  (i_nreset),
        .store_bus (line_bus)
    );

    // SRRIP state and victim choice
    rrip_select #(
        .WAYS      (WAYS),
        .RRPV_BITS (RRPV_BITS)
    ) rrip_select_inst (
        .i_clk    (i_clk),
        .i_nreset (i_nreset),
        .rrip_bus (rrip_bus)
    );

    bank_ctrl #(
        .WAYS      (WAYS),
        .RRPV_BITS (RRPV_BITS)
    ) bank_ctrl_inst (
        .i_clk               (i_clk),
        .i_nreset            (i_nreset),
        .i_request_type      (i_request_type),
        .i_addr              (i_addr),
        .i_type_valid        (i_type_valid),
        .o_type_ready        (o_type_ready),
        .i_data              (i_data),
        .o_pe_data_o         (o_pe_data_o),
        .o_pe_data_o_valid   (o_pe_data_o_valid),
        .i_pe_data_o_ready   (i_pe_data_o_ready),
        .o_dram_addr         (o_dram_addr),
        .i_dram_data         (i_dram_data),
        .i_dram_data_i_valid (i_dram_data_i_valid),
        .o_dram_data_i_ready (o_dram_data_i_ready),
        .o_dram_data_o       (o_dram_data_o),
        .o_dram_data_o_valid (o_dram_data_o_valid),
        .i_dram_data_o_ready (i_dram_data_o_ready),
        .line_bus            (line_bus),
        .rrip_bus            (rrip_bus)
    );

endmodule

// File: verilog/cache_bank_pkg.sv
package cache_bank_pkg;

    // address layout, tag | set | byte offset
    localparam int ADDR_WIDTH  = 32;
    localparam int OFFSET_BITS = 4;
    localparam int SET_BITS    = 4;
    localparam int TAG_BITS    = ADDR_WIDTH - SET_BITS - OFFSET_BITS;
    localparam int DATA_WIDTH  = 16;

    // request kinds on i_request_type
    localparam logic [1:0] REQ_FETCH = 2'd0;
    localparam logic [1:0] REQ_READ  = 2'd1;
    localparam logic [1:0] REQ_WRITE = 2'd2;

    // one address word, seen whole or split into its fields
    typedef union packed {
        logic [ADDR_WIDTH-1:0] raw;
        struct packed {
            logic [TAG_BITS-1:0]    tag;
            logic [SET_BITS-1:0]    set;
            logic [OFFSET_BITS-1:0] offset;
        } fields;
    } line_addr_u;

endpackage

// File: verilog/line_store.sv
`timescale 1ns/1ps

module line_store
    import cache_bank_pkg::*;
#(
    parameter int WAYS = 4
) (
    input  logic  i_clk,
    input  logic  i_nreset,
    line_if.store store_bus
);

    localparam int SETS = 1 << SET_BITS;

    logic [TAG_BITS-1:0]   tag_mem  [SETS][WAYS];
    logic [DATA_WIDTH-1:0] data_mem [SETS][WAYS];
    logic [WAYS-1:0]       valid_q  [SETS];
    logic [WAYS-1:0]       dirty_q  [SETS];

    logic [SET_BITS-1:0]   set_idx;
    logic [TAG_BITS-1:0]   req_tag;

    assign set_idx = store_bus.req_addr.fields.set;
    assign req_tag = store_bus.req_addr.fields.tag;

    assign store_bus.valid_vec = valid_q[set_idx];

    // -------------------------------------------------------------------------
    // tag compare and read muxes
    // -------------------------------------------------------------------------
    always_comb begin
        store_bus.hit_way  = '0;
        store_bus.hit_data = '0;
        for (int w = 0; w < WAYS; w++) begin
            if (valid_q[set_idx][w] && tag_mem[set_idx][w] == req_tag) begin
                store_bus.hit_way[w] = 1'b1;
                store_bus.hit_data   = store_bus.hit_data | data_mem[set_idx][w];
            end
        end
        store_bus.hit = |store_bus.hit_way;
    end

    // way named by fill_way, used as write-back source
    always_comb begin
        store_bus.victim_tag   = '0;
        store_bus.victim_data  = '0;
        store_bus.victim_dirty = 1'b0;
        for (int w = 0; w < WAYS; w++) begin
            if (store_bus.fill_way[w]) begin
                store_bus.victim_tag   = store_bus.victim_tag | tag_mem[set_idx][w];
                store_bus.victim_data  = store_bus.victim_data | data_mem[set_idx][w];
                store_bus.victim_dirty = store_bus.victim_dirty
                                       | (valid_q[set_idx][w] & dirty_q[set_idx][w]);
            end
        end
    end

    // -------------------------------------------------------------------------
    // array writes
    // -------------------------------------------------------------------------
    always_ff @(posedge i_clk) begin
        for (int w = 0; w < WAYS; w++) begin
            if (store_bus.fill_en && store_bus.fill_way[w]) begin
                data_mem[set_idx][w] <= store_bus.fill_data;
                tag_mem[set_idx][w]  <= req_tag;
            end else if (store_bus.wr_hit_en && store_bus.hit_way[w]) begin
                data_mem[set_idx][w] <= store_bus.wr_data;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_nreset) begin
            for (int s = 0; s < SETS; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
            end
        end else begin
            for (int w = 0; w < WAYS; w++) begin
                if (store_bus.fill_en && store_bus.fill_way[w]) begin
                    valid_q[set_idx][w] <= 1'b1;
                    dirty_q[set_idx][w] <= 1'b0;
                end else if (store_bus.wr_hit_en && store_bus.hit_way[w]) begin
                    // written lines go back to DRAM on eviction
                    dirty_q[set_idx][w] <= 1'b1;
                end
            end
        end
    end

endmodule

// File: verilog/rrip_select.sv
`timescale 1ns/1ps

module rrip_select
    import cache_bank_pkg::*;
#(
    parameter int WAYS      = 4,
    parameter int RRPV_BITS = 2
) (
    input  logic i_clk,
    input  logic i_nreset,
    rrip_if.sel  rrip_bus
);

    localparam int SETS = 1 << SET_BITS;
    localparam logic [RRPV_BITS-1:0] RRPV_MAX    = '1;
    localparam logic [RRPV_BITS-1:0] RRPV_INSERT = RRPV_MAX - 1'b1;

    logic [RRPV_BITS-1:0] rrpv [SETS][WAYS];
    logic [RRPV_BITS-1:0] max_rrpv;

    // -------------------------------------------------------------------------
    // victim: first invalid way, else first way holding the largest RRPV
    // -------------------------------------------------------------------------
    always_comb begin
        logic found;
        found    = 1'b0;
        max_rrpv = '0;
        rrip_bus.victim_way = '0;
        for (int w = 0; w < WAYS; w++) begin
            if (rrpv[rrip_bus.set_idx][w] > max_rrpv)
                max_rrpv = rrpv[rrip_bus.set_idx][w];
        end
        for (int w = 0; w < WAYS; w++) begin
            if (!found && !rrip_bus.valid_vec[w]) begin
                rrip_bus.victim_way[w] = 1'b1;
                found = 1'b1;
            end
        end
        for (int w = 0; w < WAYS; w++) begin
            if (!found && rrpv[rrip_bus.set_idx][w] == max_rrpv) begin
                rrip_bus.victim_way[w] = 1'b1;
                found = 1'b1;
            end
        end
    end

    // hit promotes to near, miss ages the set and inserts at long
    always_ff @(posedge i_clk) begin
        if (!i_nreset) begin
            for (int s = 0; s < SETS; s++) begin
                for (int w = 0; w < WAYS; w++)
                    rrpv[s][w] <= RRPV_MAX;
            end
        end else if (rrip_bus.touch_en) begin
            for (int w = 0; w < WAYS; w++) begin
                if (rrip_bus.hit_way[w])
                    rrpv[rrip_bus.set_idx][w] <= '0;
            end
        end else if (rrip_bus.miss_en) begin
            for (int w = 0; w < WAYS; w++) begin
                if (rrip_bus.victim_way[w])
                    rrpv[rrip_bus.set_idx][w] <= RRPV_INSERT;
                else if (rrpv[rrip_bus.set_idx][w] != RRPV_MAX)
                    rrpv[rrip_bus.set_idx][w] <= rrpv[rrip_bus.set_idx][w] + 1'b1;
            end
        end
    end

endmodule
